//--- logic/sysctrl_pkg.sv
`default_nettype none

package sysctrl_pkg;

    typedef logic [3:0]  axi_addr_t;     // Register byte address.
    typedef logic [31:0] axi_data_t;     // Register data word.
    typedef logic [1:0]  axi_resp_t;     // AXI response code.

    localparam axi_resp_t resp_okay   = 2'b00;
    localparam axi_resp_t resp_slverr = 2'b10;

    // Sequencer cycle counter, room for ~146 ms at 114.5 MHz.
    typedef logic [23:0] reset_count_t;

    typedef logic [31:0] phi_count_t;    // Phi rising edge counter.

    // Register map.
    localparam axi_addr_t reg_ctrl_addr      = 4'h0;  // Turbo and reset request.
    localparam axi_addr_t reg_status_addr    = 4'h4;  // Read-only status bits.
    localparam axi_addr_t reg_phi_count_addr = 4'h8;  // Read-only phi count.

    // Reset sequencer states.
    typedef enum logic [1:0] {
        seq_drive,      // Pulling the bus reset low.
        seq_release,    // Let go, waiting for the line to rise.
        seq_stretch,    // Bus is free, core still held.
        seq_run         // Core running.
    } seq_state_t;

endpackage

`default_nettype wire

//--- logic/reset_sync.sv
`timescale 1ns/1ps
`default_nettype none

module reset_sync #(
    parameter int SYNC_STAGES = 2
) (
    input  logic sysclk,
    input  logic ext_reset_synced,
    input  logic async_n,       // Asynchronous, active low.
    output logic sync_high      // Synchronized, active high.
);

    logic [SYNC_STAGES-1:0] chain;  // Metastability chain.

    // Preset to all ones, the bus counts as held in reset at power-up.
    always_ff @(posedge sysclk) begin
        if (ext_reset_synced) begin
            chain <= '1;
        end else begin
            chain <= {chain[SYNC_STAGES-2:0], ~async_n};  // Shift in inverted line.
        end
    end

    assign sync_high = chain[SYNC_STAGES-1];  // Last stage only.

    // A single flop gives no settling time.
    a_sync_stages: assert property (@(posedge sysclk) SYNC_STAGES >= 2);

endmodule

`default_nettype wire

//--- logic/reset_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer #(
    parameter int EXT_RESET_CYCLES  = 16_777_215,
    parameter int CORE_RESET_CYCLES = 16
) (
    input  logic sysclk,
    input  logic ext_reset_synced,
    input  logic reset_req,         // One-cycle request from the host.
    input  logic bus_reset_low,     // Bus reset seen low, synchronized.
    output logic ebus_reset_drive,  // 1 pulls the bus reset low.
    output logic core_reset         // Internal core reset, active high.
);

    localparam sysctrl_pkg::reset_count_t ext_last =
        sysctrl_pkg::reset_count_t'(EXT_RESET_CYCLES - 1);
    localparam sysctrl_pkg::reset_count_t core_last =
        sysctrl_pkg::reset_count_t'(CORE_RESET_CYCLES - 1);

    sysctrl_pkg::seq_state_t   state;
    sysctrl_pkg::reset_count_t count;   // Shared by drive and stretch.

    always_ff @(posedge sysclk) begin
        if (ext_reset_synced) begin
            state <= sysctrl_pkg::seq_drive;  // Power-up starts with a bus reset.
            count <= '0;
        end else if (reset_req) begin
            state <= sysctrl_pkg::seq_drive;  // Restart from any state.
            count <= '0;
        end else begin
            case (state)
                sysctrl_pkg::seq_drive: begin
                    if (count == ext_last) begin
                        state <= sysctrl_pkg::seq_release;
                        count <= '0;
                    end else begin
                        count <= count + 1'b1;
                    end
                end

                // Unbounded wait, any other device may still hold the line.
                sysctrl_pkg::seq_release: begin
                    if (!bus_reset_low) begin
                        state <= sysctrl_pkg::seq_stretch;
                        count <= sysctrl_pkg::reset_count_t'(1);  // This cycle counts.
                    end
                end

                sysctrl_pkg::seq_stretch: begin
                    if (bus_reset_low) begin
                        state <= sysctrl_pkg::seq_release;  // Line pulled again.
                        count <= '0;
                    end else if (count >= core_last) begin
                        state <= sysctrl_pkg::seq_run;
                        count <= '0;
                    end else begin
                        count <= count + 1'b1;
                    end
                end

                sysctrl_pkg::seq_run: begin
                    if (bus_reset_low) begin
                        state <= sysctrl_pkg::seq_release;  // Peer reset, hold the core.
                    end
                end

                default: begin
                    state <= sysctrl_pkg::seq_drive;
                    count <= '0;
                end
            endcase
        end
    end

    // Both outputs decode straight from the state register.
    assign ebus_reset_drive = (state == sysctrl_pkg::seq_drive);
    assign core_reset       = (state != sysctrl_pkg::seq_run);

    // The bus is never pulled while the core runs, drive never leads straight to run.
    a_no_drive_in_run: assert property (
        @(posedge sysclk) disable iff (ext_reset_synced)
        ebus_reset_drive |=> core_reset);

    // A low bus line holds the core from the next cycle on.
    a_core_held: assert property (
        @(posedge sysclk) disable iff (ext_reset_synced)
        bus_reset_low |=> core_reset);

endmodule

`default_nettype wire

//--- logic/phi_divider.sv
`timescale 1ns/1ps
`default_nettype none

module phi_divider (
    input  logic                    sysclk,
    input  logic                    ext_reset_synced,
    input  logic                    core_reset,    // Clears only the edge counter.
    input  logic                    turbo,         // 1 halves the phi period.
    output logic                    ebus_phi,
    output sysctrl_pkg::phi_count_t phi_count
);

    logic       phi;        // Phi level.
    logic [1:0] prescale;   // Sysclk cycles into the half period.
    logic [1:0] terminal;   // Last prescale value before a toggle.
    logic       toggle;
    logic       phi_rise;

    // 4 cycles per half period, or 2 in turbo.
    assign terminal = turbo ? 2'd1 : 2'd3;

    // >= catches a prescaler already past a lowered terminal.
    assign toggle   = (prescale >= terminal);
    assign phi_rise = toggle && !phi;  // Low to high next cycle.

    // Phi keeps running through core reset, the bus needs its clock then.
    always_ff @(posedge sysclk) begin
        if (ext_reset_synced) begin
            phi      <= 1'b0;
            prescale <= 2'd0;
        end else if (toggle) begin
            phi      <= !phi;
            prescale <= 2'd0;
        end else begin
            prescale <= prescale + 2'd1;
        end
    end

    always_ff @(posedge sysclk) begin
        if (ext_reset_synced || core_reset) begin
            phi_count <= '0;  // Restarts after every core reset.
        end else if (phi_rise) begin
            phi_count <= phi_count + 1'b1;
        end
    end

    assign ebus_phi = phi;

    // Past the terminal only right after a switch into turbo.
    a_prescale_range: assert property (
        @(posedge sysclk) disable iff (ext_reset_synced)
        (prescale > terminal) |-> $rose(turbo));

endmodule

`default_nettype wire

//--- logic/sysctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module sysctrl_regs (
    input  logic                    sysclk,
    input  logic                    ext_reset_synced,

    // AXI4-Lite write address and data.
    input  sysctrl_pkg::axi_addr_t  s_awaddr,
    input  logic                    s_awvalid,
    output logic                    s_awready,
    input  sysctrl_pkg::axi_data_t  s_wdata,
    input  logic [3:0]              s_wstrb,
    input  logic                    s_wvalid,
    output logic                    s_wready,

    // Write response.
    output sysctrl_pkg::axi_resp_t  s_bresp,
    output logic                    s_bvalid,
    input  logic                    s_bready,

    // Read address and data.
    input  sysctrl_pkg::axi_addr_t  s_araddr,
    input  logic                    s_arvalid,
    output logic                    s_arready,
    output sysctrl_pkg::axi_data_t  s_rdata,
    output sysctrl_pkg::axi_resp_t  s_rresp,
    output logic                    s_rvalid,
    input  logic                    s_rready,

    // Status sources.
    input  logic                    bus_reset_low,
    input  logic                    ebus_reset_drive,
    input  logic                    core_reset,
    input  sysctrl_pkg::phi_count_t phi_count,

    output logic                    turbo,
    output logic                    reset_req     // One-cycle pulse.
);

    logic                   wr_ready;   // Drives both awready and wready.
    logic                   wr_hs;
    logic                   wr_mapped;
    logic                   rd_hs;
    logic                   rd_mapped;
    sysctrl_pkg::axi_data_t rd_mux;
    sysctrl_pkg::axi_data_t status;

    assign status = {28'd0, turbo, ebus_reset_drive, bus_reset_low, core_reset};

    // Write side. Address and data are taken together.
    assign wr_hs     = wr_ready && s_awvalid && s_wvalid;
    assign wr_mapped = (s_awaddr == sysctrl_pkg::reg_ctrl_addr)
                    || (s_awaddr == sysctrl_pkg::reg_status_addr)
                    || (s_awaddr == sysctrl_pkg::reg_phi_count_addr);

    always_ff @(posedge sysclk) begin
        if (ext_reset_synced) begin
            wr_ready  <= 1'b0;
            s_bvalid  <= 1'b0;
            s_bresp   <= sysctrl_pkg::resp_okay;
            turbo     <= 1'b0;
            reset_req <= 1'b0;
        end else begin
            // Single-cycle ready, held off while a response waits.
            wr_ready  <= s_awvalid && s_wvalid && !s_bvalid && !wr_ready;
            reset_req <= 1'b0;
            if (wr_hs) begin
                s_bvalid <= 1'b1;
                s_bresp  <= wr_mapped ? sysctrl_pkg::resp_okay : sysctrl_pkg::resp_slverr;
                if (s_awaddr == sysctrl_pkg::reg_ctrl_addr && s_wstrb[0]) begin
                    turbo     <= s_wdata[0];
                    reset_req <= s_wdata[1];  // Write-one, never stored.
                end
            end else if (s_bready) begin
                s_bvalid <= 1'b0;
            end
        end
    end

    assign s_awready = wr_ready;
    assign s_wready  = wr_ready;

    // Read side.
    assign rd_hs = s_arready && s_arvalid;

    always_comb begin
        rd_mux    = '0;     // Unmapped reads return zero.
        rd_mapped = 1'b1;
        case (s_araddr)
            sysctrl_pkg::reg_ctrl_addr:      rd_mux = {31'd0, turbo};  // Bit 1 reads 0.
            sysctrl_pkg::reg_status_addr:    rd_mux = status;
            sysctrl_pkg::reg_phi_count_addr: rd_mux = phi_count;
            default:                         rd_mapped = 1'b0;
        endcase
    end

    always_ff @(posedge sysclk) begin
        if (ext_reset_synced) begin
            s_arready <= 1'b0;
            s_rvalid  <= 1'b0;
            s_rresp   <= sysctrl_pkg::resp_okay;
        end else begin
            s_arready <= s_arvalid && !s_rvalid && !s_arready;
            if (rd_hs) begin
                s_rvalid <= 1'b1;
                s_rresp  <= rd_mapped ? sysctrl_pkg::resp_okay : sysctrl_pkg::resp_slverr;
            end else if (s_rready) begin
                s_rvalid <= 1'b0;
            end
        end
    end

    // Read data is payload, captured at the handshake.
    always_ff @(posedge sysclk) begin
        if (rd_hs) begin
            s_rdata <= rd_mux;
        end
    end

    a_bvalid_hold: assert property (
        @(posedge sysclk) disable iff (ext_reset_synced)
        s_bvalid && !s_bready |=> s_bvalid && $stable(s_bresp));

    a_rvalid_hold: assert property (
        @(posedge sysclk) disable iff (ext_reset_synced)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata) && $stable(s_rresp));

endmodule

`default_nettype wire

//--- logic/sysctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module sysctrl_top #(
    parameter int EXT_RESET_CYCLES  = 16_777_215,  // About 146 ms at 114.5 MHz.
    parameter int CORE_RESET_CYCLES = 16,
    parameter int SYNC_STAGES       = 2
) (
    input  logic                    sysclk,
    input  logic                    ext_reset_synced,

    // Expansion bus.
    output logic                    ebus_reset_drive,  // 1 pulls the line low.
    input  logic                    ebus_reset_n_in,   // Line as seen on the pad.
    output logic                    ebus_phi,

    output logic                    core_reset,

    // AXI4-Lite slave.
    input  sysctrl_pkg::axi_addr_t  s_awaddr,
    input  logic                    s_awvalid,
    output logic                    s_awready,
    input  sysctrl_pkg::axi_data_t  s_wdata,
    input  logic [3:0]              s_wstrb,
    input  logic                    s_wvalid,
    output logic                    s_wready,
    output sysctrl_pkg::axi_resp_t  s_bresp,
    output logic                    s_bvalid,
    input  logic                    s_bready,
    input  sysctrl_pkg::axi_addr_t  s_araddr,
    input  logic                    s_arvalid,
    output logic                    s_arready,
    output sysctrl_pkg::axi_data_t  s_rdata,
    output sysctrl_pkg::axi_resp_t  s_rresp,
    output logic                    s_rvalid,
    input  logic                    s_rready
);

    logic                    reset_req;      // Host reset request pulse.
    logic                    turbo;
    logic                    bus_reset_low;  // Synced bus reset, any driver.
    sysctrl_pkg::phi_count_t phi_count;

    // Bus line back into sysclk.
    reset_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) i_reset_sync (
        .sysclk           (sysclk),
        .ext_reset_synced (ext_reset_synced),
        .async_n          (ebus_reset_n_in),
        .sync_high        (bus_reset_low)
    );

    reset_sequencer #(
        .EXT_RESET_CYCLES  (EXT_RESET_CYCLES),
        .CORE_RESET_CYCLES (CORE_RESET_CYCLES)
    ) i_reset_sequencer (
        .sysclk           (sysclk),
        .ext_reset_synced (ext_reset_synced),
        .reset_req        (reset_req),
        .bus_reset_low    (bus_reset_low),
        .ebus_reset_drive (ebus_reset_drive),
        .core_reset       (core_reset)
    );

    phi_divider i_phi_divider (
        .sysclk           (sysclk),
        .ext_reset_synced (ext_reset_synced),
        .core_reset       (core_reset),
        .turbo            (turbo),
        .ebus_phi         (ebus_phi),
        .phi_count        (phi_count)
    );

    sysctrl_regs i_sysctrl_regs (
        .sysclk           (sysclk),
        .ext_reset_synced (ext_reset_synced),
        .s_awaddr         (s_awaddr),
        .s_awvalid        (s_awvalid),
        .s_awready        (s_awready),
        .s_wdata          (s_wdata),
        .s_wstrb          (s_wstrb),
        .s_wvalid         (s_wvalid),
        .s_wready         (s_wready),
        .s_bresp          (s_bresp),
        .s_bvalid         (s_bvalid),
        .s_bready         (s_bready),
        .s_araddr         (s_araddr),
        .s_arvalid        (s_arvalid),
        .s_arready        (s_arready),
        .s_rdata          (s_rdata),
        .s_rresp          (s_rresp),
        .s_rvalid         (s_rvalid),
        .s_rready         (s_rready),
        .bus_reset_low    (bus_reset_low),
        .ebus_reset_drive (ebus_reset_drive),
        .core_reset       (core_reset),
        .phi_count        (phi_count),
        .turbo            (turbo),
        .reset_req        (reset_req)
    );

endmodule

`default_nettype wire

//--- verif/tb_sysctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sysctrl;

    localparam int EXT_RESET_CYCLES  = 20;
    localparam int CORE_RESET_CYCLES = 16;
    localparam int SYNC_STAGES       = 2;
    localparam int CORE_BOUND        = SYNC_STAGES + 1 + CORE_RESET_CYCLES;  // Release to run.

    typedef enum logic [2:0] {
        op_write,       // AXI write, check response.
        op_read,        // AXI read, check data and response.
        op_peer,        // Peer line level, data bit 0.
        op_wait,        // Idle for data cycles.
        op_phi,         // Phi rising edge spacing.
        op_phi_count,   // PHI_COUNT delta over data cycles.
        op_reset_seq,   // Drive length, then core release.
        op_core         // Core release after a peer hold.
    } op_t;

    typedef struct {
        op_t                    op;
        sysctrl_pkg::axi_addr_t addr;
        sysctrl_pkg::axi_data_t data;
        logic [3:0]             strb;
        sysctrl_pkg::axi_data_t exp_data;
        sysctrl_pkg::axi_resp_t exp_resp;
        int                     tol;
    } row_t;

    row_t table_q[$];

    logic sysclk;
    logic ext_reset_synced;
    logic ebus_reset_drive;
    logic ebus_reset_n_in;
    logic ebus_phi;
    logic core_reset;
    logic peer_hold_n;                  // 0 while a peer pulls the line.
    sysctrl_pkg::axi_addr_t s_awaddr;
    logic                   s_awvalid;
    logic                   s_awready;
    sysctrl_pkg::axi_data_t s_wdata;
    logic [3:0]             s_wstrb;
    logic                   s_wvalid;
    logic                   s_wready;
    sysctrl_pkg::axi_resp_t s_bresp;
    logic                   s_bvalid;
    logic                   s_bready;
    sysctrl_pkg::axi_addr_t s_araddr;
    logic                   s_arvalid;
    logic                   s_arready;
    sysctrl_pkg::axi_data_t s_rdata;
    sysctrl_pkg::axi_resp_t s_rresp;
    logic                   s_rvalid;
    logic                   s_rready;

    integer seed;
    int     error_count;
    int     cycle_count;
    int     cycle_limit;
    int     drive_run;                  // Drive-high cycles so far.
    int     drive_len;                  // Length of the last drive pulse.

    // Open-drain bus line, either side pulls it low.
    assign ebus_reset_n_in = !ebus_reset_drive && peer_hold_n;

    sysctrl_top #(
        .EXT_RESET_CYCLES  (EXT_RESET_CYCLES),
        .CORE_RESET_CYCLES (CORE_RESET_CYCLES),
        .SYNC_STAGES       (SYNC_STAGES)
    ) i_sysctrl_top (
        .sysclk (sysclk), .ext_reset_synced (ext_reset_synced),
        .ebus_reset_drive (ebus_reset_drive), .ebus_reset_n_in (ebus_reset_n_in),
        .ebus_phi (ebus_phi), .core_reset (core_reset),
        .s_awaddr (s_awaddr), .s_awvalid (s_awvalid), .s_awready (s_awready),
        .s_wdata (s_wdata), .s_wstrb (s_wstrb), .s_wvalid (s_wvalid), .s_wready (s_wready),
        .s_bresp (s_bresp), .s_bvalid (s_bvalid), .s_bready (s_bready),
        .s_araddr (s_araddr), .s_arvalid (s_arvalid), .s_arready (s_arready),
        .s_rdata (s_rdata), .s_rresp (s_rresp), .s_rvalid (s_rvalid), .s_rready (s_rready)
    );

    always #2 sysclk = !sysclk;  // 4 ns period.

    // Drive pulse length, measured mid-cycle.
    always @(negedge sysclk) begin
        if (ext_reset_synced) begin
            drive_run = 0;
        end else if (ebus_reset_drive) begin
            drive_run = drive_run + 1;
        end else if (drive_run != 0) begin
            drive_len = drive_run;  // Pulse just ended.
            drive_run = 0;
        end
    end

    always @(posedge sysclk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("Timeout: no progress after %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

    task automatic stop_on_error(input string msg);
        error_count = error_count + 1;
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input sysctrl_pkg::axi_data_t got,
                              input sysctrl_pkg::axi_data_t exp, input int tol);
        sysctrl_pkg::axi_data_t diff;
        diff = (got > exp) ? got - exp : exp - got;  // Distance, either side.
        if ($isunknown(got) || diff > sysctrl_pkg::axi_data_t'(tol)) begin
            stop_on_error($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_resp(input string name, input sysctrl_pkg::axi_resp_t got,
                              input sysctrl_pkg::axi_resp_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic tick;
        @(posedge sysclk);
        #1;  // Drive and sample clear of the edge.
    endtask

    task automatic axi_write(input sysctrl_pkg::axi_addr_t addr,
                             input sysctrl_pkg::axi_data_t data, input logic [3:0] strb,
                             output sysctrl_pkg::axi_resp_t resp);
        int delay;
        delay     = $unsigned($random(seed)) % 4;  // Back-pressure on B.
        s_awaddr  = addr;
        s_wdata   = data;
        s_wstrb   = strb;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        do tick(); while (!s_awready);
        check_bit("s_wready", s_wready, 1'b1);  // Rises with awready.
        tick();                              // Handshake edge.
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        while (!s_bvalid) tick();
        repeat (delay) tick();
        resp     = s_bresp;
        s_bready = 1'b1;
        tick();
        s_bready = 1'b0;
    endtask

    task automatic axi_read(input sysctrl_pkg::axi_addr_t addr, input logic use_random,
                            output sysctrl_pkg::axi_data_t data,
                            output sysctrl_pkg::axi_resp_t resp);
        int delay;
        delay     = use_random ? $unsigned($random(seed)) % 4 : 0;
        s_araddr  = addr;
        s_arvalid = 1'b1;
        do tick(); while (!s_arready);
        tick();
        s_arvalid = 1'b0;
        while (!s_rvalid) tick();
        repeat (delay) tick();
        data     = s_rdata;
        resp     = s_rresp;
        s_rready = 1'b1;
        tick();
        s_rready = 1'b0;
    endtask

    // Cycles up to the next low-to-high step of phi.
    task automatic wait_phi_rise(output int n);
        logic prev;
        n    = 0;
        prev = ebus_phi;
        tick();
        n = n + 1;
        while (!(!prev && ebus_phi)) begin
            prev = ebus_phi;
            tick();
            n = n + 1;
        end
    endtask

    // Bounded wait for core release, at most bound cycles.
    task automatic wait_core_release(input int bound);
        int n;
        n = 0;
        while (core_reset && n < bound) begin
            tick();
            n = n + 1;
        end
        if (core_reset) stop_on_error("core_reset stayed high past its bound");
    endtask

    task automatic apply_row(input row_t r);
        sysctrl_pkg::axi_data_t rd;
        sysctrl_pkg::axi_data_t first;
        sysctrl_pkg::axi_resp_t resp;
        int                     n;
        case (r.op)
            op_write: begin
                axi_write(r.addr, r.data, r.strb, resp);
                check_resp("s_bresp", resp, r.exp_resp);
            end
            op_read: begin
                axi_read(r.addr, 1'b1, rd, resp);
                check_data("s_rdata", rd, r.exp_data, r.tol);
                check_resp("s_rresp", resp, r.exp_resp);
            end
            op_peer: begin
                peer_hold_n = r.data[0];
                tick();
            end
            op_wait: repeat (r.data) tick();
            op_phi: begin
                wait_phi_rise(n);                // Skip a possible turbo switch.
                wait_phi_rise(n);
                wait_phi_rise(n);
                check_data("phi period", sysctrl_pkg::axi_data_t'(n), r.exp_data, 0);
            end
            op_phi_count: begin
                axi_read(sysctrl_pkg::reg_phi_count_addr, 1'b0, first, resp);
                repeat (r.data) tick();
                axi_read(sysctrl_pkg::reg_phi_count_addr, 1'b0, rd, resp);
                check_data("phi_count delta", rd - first, r.exp_data, r.tol);
            end
            op_reset_seq: begin
                while (!ebus_reset_drive) tick();
                check_bit("core_reset", core_reset, 1'b1);
                while (ebus_reset_drive) tick();
                tick();                          // Let the monitor log the pulse.
                check_data("drive length", sysctrl_pkg::axi_data_t'(drive_len),
                           r.exp_data, 0);
                wait_core_release(r.data - 1);
            end
            default: wait_core_release(r.data - 1);  // Peer row took one cycle.
        endcase
    endtask

    task automatic add_row(input op_t op, input sysctrl_pkg::axi_addr_t addr,
                           input sysctrl_pkg::axi_data_t data, input logic [3:0] strb,
                           input sysctrl_pkg::axi_data_t exp_data,
                           input sysctrl_pkg::axi_resp_t exp_resp, input int tol);
        row_t r;
        r = '{op, addr, data, strb, exp_data, exp_resp, tol};
        table_q.push_back(r);
    endtask

    // Worst-case cycles a row can take.
    function automatic int row_cycles(input row_t r);
        case (r.op)
            op_write, op_read: return 12;
            op_peer:           return 2;
            op_wait:           return r.data;
            op_phi:            return 30;
            op_phi_count:      return r.data + 20;
            op_reset_seq:      return EXT_RESET_CYCLES + r.data + 20;
            default:           return r.data + 2;
        endcase
    endfunction

    initial begin
        sysclk           = 1'b0;
        ext_reset_synced = 1'b1;
        peer_hold_n      = 1'b1;
        s_awaddr         = '0;
        s_awvalid        = 1'b0;
        s_wdata          = '0;
        s_wstrb          = '0;
        s_wvalid         = 1'b0;
        s_bready         = 1'b0;
        s_araddr         = '0;
        s_arvalid        = 1'b0;
        s_rready         = 1'b0;
        seed             = 20373;
        error_count      = 0;
        cycle_count      = 0;
        cycle_limit      = 0;
        drive_run        = 0;
        drive_len        = 0;

        add_row(op_reset_seq, 4'h0, CORE_BOUND, 4'h0, EXT_RESET_CYCLES, 2'b00, 0);
        add_row(op_read,  sysctrl_pkg::reg_status_addr, 0, 4'h0, 32'h0, 2'b00, 0);
        add_row(op_write, sysctrl_pkg::reg_ctrl_addr, 32'h0, 4'hf, 0, 2'b00, 0);
        add_row(op_phi,   4'h0, 0, 4'h0, 8, 2'b00, 0);   // Normal, 4 + 4.
        add_row(op_phi_count, 4'h0, 77, 4'h0, 10, 2'b00, 1);  // 80 cycles apart.
        add_row(op_write, sysctrl_pkg::reg_ctrl_addr, 32'h1, 4'hf, 0, 2'b00, 0);
        add_row(op_read,  sysctrl_pkg::reg_ctrl_addr, 0, 4'h0, 32'h1, 2'b00, 0);
        add_row(op_read,  sysctrl_pkg::reg_status_addr, 0, 4'h0, 32'h8, 2'b00, 0);
        add_row(op_phi,   4'h0, 0, 4'h0, 4, 2'b00, 0);   // Turbo, 2 + 2.
        add_row(op_phi_count, 4'h0, 77, 4'h0, 20, 2'b00, 1);
        add_row(op_write, sysctrl_pkg::reg_ctrl_addr, 32'h0, 4'h0, 0, 2'b00, 0);
        add_row(op_read,  sysctrl_pkg::reg_ctrl_addr, 0, 4'h0, 32'h1, 2'b00, 0);
        add_row(op_write, 4'hc, 32'h0, 4'hf, 0, sysctrl_pkg::resp_slverr, 0);
        add_row(op_read,  4'hc, 0, 4'h0, 32'h0, sysctrl_pkg::resp_slverr, 0);
        add_row(op_read,  sysctrl_pkg::reg_ctrl_addr, 0, 4'h0, 32'h1, 2'b00, 0);
        add_row(op_write, sysctrl_pkg::reg_ctrl_addr, 32'h3, 4'hf, 0, 2'b00, 0);
        add_row(op_reset_seq, 4'h0, CORE_BOUND, 4'h0, EXT_RESET_CYCLES, 2'b00, 0);
        add_row(op_read,  sysctrl_pkg::reg_phi_count_addr, 0, 4'h0, 32'h0, 2'b00, 2);
        add_row(op_read,  sysctrl_pkg::reg_ctrl_addr, 0, 4'h0, 32'h1, 2'b00, 0);
        add_row(op_peer,  4'h0, 32'h0, 4'h0, 0, 2'b00, 0);  // Peer pulls the line.
        add_row(op_wait,  4'h0, 20, 4'h0, 0, 2'b00, 0);
        add_row(op_read,  sysctrl_pkg::reg_status_addr, 0, 4'h0, 32'hb, 2'b00, 0);
        add_row(op_peer,  4'h0, 32'h1, 4'h0, 0, 2'b00, 0);
        add_row(op_core,  4'h0, CORE_BOUND, 4'h0, 0, 2'b00, 0);
        add_row(op_read,  sysctrl_pkg::reg_status_addr, 0, 4'h0, 32'h8, 2'b00, 0);

        cycle_limit = 2 + 200;  // Reset plus margin.
        foreach (table_q[i]) cycle_limit = cycle_limit + row_cycles(table_q[i]);

        repeat (2) @(posedge sysclk);
        #1;
        ext_reset_synced = 1'b0;

        foreach (table_q[i]) apply_row(table_q[i]);

        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
logic/sysctrl_pkg.sv
logic/reset_sync.sv
logic/reset_sequencer.sv
logic/phi_divider.sv
logic/sysctrl_regs.sv
logic/sysctrl_top.sv
verif/tb_sysctrl.sv

//--- Makefile
SRCS := $(shell cat flist.f)
BIN  := obj_dir/Vtb_sysctrl

.PHONY: all run clean

all: run

$(BIN): $(SRCS) flist.f
	verilator --binary --timing --assert -sv -Wno-fatal --top-module tb_sysctrl \
		-Mdir obj_dir -f flist.f

run: $(BIN)
	-./$(BIN) > sim.log 2>&1
	@cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
